/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// addi x0, x0, 0
`define NOP_IR 32'h0000_0013

// pc value that marks a bubble slot on the fetch output
`define NOP_PC 32'hFFFF_FFFF

// instruction memory geometry, in words
`define IMEM_DEPTH 256
`define IMEM_AW    8      // log2 of depth

`endif

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // basic widths
    typedef logic [31:0] word_t;   // instruction or data word
    typedef logic [15:0] half_t;   // compressed instr, saved upper half
    typedef logic [31:0] addr_t;   // byte address / pc

    // fetch alignment fsm, one-hot
    typedef enum logic [4:0] {
        S_STARTUP        = 5'b00001,   // waiting on first memory read
        S_ALIGNED        = 5'b00010,   // next instr starts at word bit 0
        S_UNALIGNED      = 5'b00100,   // next instr starts at word bit 16
        S_UNALIGNED_JUMP = 5'b01000,   // fetching word of an unaligned target
        S_HALTED         = 5'b10000    // sticky until reset
    } fetch_state_t;

endpackage

/* verilog/cpu_decompress.sv */
module cpu_decompress (
    input  cpu_pkg::word_t ir_i,
    output cpu_pkg::word_t ir_o,
    output logic           compressed_o
);
    import cpu_pkg::*;

    // rv32i major opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    half_t       c_w;        // low halfword under decode
    logic [2:0]  funct3_w;
    logic [4:0]  rd_w;       // full 5-bit rd / rs1
    logic [4:0]  rs2_w;
    logic [4:0]  rs1p_w;     // x8..x15 from bits 9:7
    logic [4:0]  rs2p_w;     // x8..x15 from bits 4:2
    logic [11:0] ci_imm_w;   // sign extended 6-bit immediate
    logic [11:0] mem_imm_w;  // c.lw / c.sw word offset
    logic [11:0] cj_off_w;
    logic [20:0] jal_imm_w;
    logic [8:0]  cb_off_w;
    logic [12:0] br_imm_w;
    word_t       expanded_w;

    assign c_w          = ir_i[15:0];
    assign compressed_o = (c_w[1:0] != 2'b11);

    assign funct3_w = c_w[15:13];
    assign rd_w     = c_w[11:7];
    assign rs2_w    = c_w[6:2];
    assign rs1p_w   = {2'b01, c_w[9:7]};
    assign rs2p_w   = {2'b01, c_w[4:2]};

    assign ci_imm_w  = {{6{c_w[12]}}, c_w[12], c_w[6:2]};
    assign mem_imm_w = {5'd0, c_w[5], c_w[12:10], c_w[6], 2'b00};

    // c.j offset scatter
    assign cj_off_w  = {c_w[12], c_w[8], c_w[10:9], c_w[6], c_w[7], c_w[2], c_w[11],
                        c_w[5:3], 1'b0};
    assign jal_imm_w = {{9{cj_off_w[11]}}, cj_off_w};

    // c.beqz / c.bnez offset scatter
    assign cb_off_w = {c_w[12], c_w[6:5], c_w[2], c_w[11:10], c_w[4:3], 1'b0};
    assign br_imm_w = {{4{cb_off_w[8]}}, cb_off_w};

    always_comb begin
        expanded_w = '0;   // unsupported encodings stay illegal
        case (c_w[1:0])
            2'b00: begin
                case (funct3_w)
                    3'b010: expanded_w = {mem_imm_w, rs1p_w, 3'b010, rs2p_w, OP_LOAD};
                    3'b110: expanded_w = {mem_imm_w[11:5], rs2p_w, rs1p_w, 3'b010,
                                          mem_imm_w[4:0], OP_STORE};
                    default: expanded_w = '0;
                endcase
            end
            2'b01: begin
                case (funct3_w)
                    3'b000: expanded_w = {ci_imm_w, rd_w, 3'b000, rd_w, OP_IMM};  // c.addi, c.nop
                    3'b010: expanded_w = {ci_imm_w, 5'd0, 3'b000, rd_w, OP_IMM};  // c.li
                    3'b011: begin
                        // rd == x2 is c.addi16sp, not handled here
                        if (rd_w != 5'd2) begin
                            expanded_w = {{8{ci_imm_w[11]}}, ci_imm_w, rd_w, OP_LUI};
                        end
                    end
                    3'b101: expanded_w = {jal_imm_w[20], jal_imm_w[10:1], jal_imm_w[11],
                                          jal_imm_w[19:12], 5'd0, OP_JAL};
                    3'b110,
                    3'b111: begin
                        // funct3 bit 0 picks bne over beq
                        expanded_w = {br_imm_w[12], br_imm_w[10:5], 5'd0, rs1p_w,
                                      {2'b00, funct3_w[0]}, br_imm_w[4:1], br_imm_w[11],
                                      OP_BRANCH};
                    end
                    default: expanded_w = '0;
                endcase
            end
            2'b10: begin
                // rs2 == 0 would be c.jr / c.jalr / c.ebreak
                if (funct3_w == 3'b100 && rs2_w != 5'd0) begin
                    if (c_w[12]) begin
                        expanded_w = {7'd0, rs2_w, rd_w, 3'b000, rd_w, OP_OP};  // c.add
                    end else begin
                        expanded_w = {7'd0, rs2_w, 5'd0, 3'b000, rd_w, OP_OP};  // c.mv
                    end
                end
            end
            default: expanded_w = ir_i;   // full 32-bit instr
        endcase
    end

    assign ir_o = expanded_w;

endmodule

/* verilog/cpu_if.sv */
`include "cpu_params.svh"

module cpu_if (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           halt_i,
    input  logic           ready_i,       // decode can take an instr
    input  logic           jmp_valid_i,
    input  cpu_pkg::addr_t jmp_addr_i,
    input  cpu_pkg::word_t imem_data_i,   // word addressed last cycle
    output cpu_pkg::addr_t imem_addr_o,
    output cpu_pkg::addr_t pc_o,
    output cpu_pkg::addr_t next_pc_o,
    output cpu_pkg::word_t ir_o
);
    import cpu_pkg::*;

    fetch_state_t state_r;
    fetch_state_t state_w;
    logic [1:0]   first_cycle_r;   // startup wait counter

    addr_t imem_addr_r;
    addr_t imem_addr_w;
    addr_t pc_r;
    addr_t next_pc_r;   // pc of the candidate instr
    addr_t jmp_addr_r;
    word_t ir_r;
    half_t saved_ir_r;  // upper half of the previous word

    word_t cand_ir_w;
    word_t expanded_ir_w;
    logic  compressed_w;

    // fsm edges
    logic halt_w;
    logic wait_w;
    logic run_w;
    logic stall_w;
    logic in_aligned_w;
    logic in_unaligned_w;
    logic aligned_jump_w;
    logic unaligned_jump_1_w;
    logic unaligned_jump_2_w;
    logic emit_w;
    logic stay_aligned_w;
    logic lose_alignment_w;
    logic stay_unaligned_w;
    logic gain_alignment_w;

    always_comb begin
        halt_w         = halt_i || (state_r == S_HALTED);
        wait_w         = !halt_w && (state_r == S_STARTUP) && first_cycle_r[0];
        run_w          = !halt_w && !wait_w && ready_i;
        stall_w        = !halt_w && !wait_w && !ready_i;
        in_aligned_w   = (state_r == S_STARTUP) || (state_r == S_ALIGNED);
        in_unaligned_w = (state_r == S_UNALIGNED);

        aligned_jump_w     = run_w && jmp_valid_i && !jmp_addr_i[1];
        unaligned_jump_1_w = run_w && jmp_valid_i && jmp_addr_i[1];
        unaligned_jump_2_w = run_w && !jmp_valid_i && (state_r == S_UNALIGNED_JUMP);

        emit_w           = run_w && !jmp_valid_i && (in_aligned_w || in_unaligned_w);
        stay_aligned_w   = emit_w && in_aligned_w && !compressed_w;
        lose_alignment_w = emit_w && in_aligned_w && compressed_w;
        stay_unaligned_w = emit_w && in_unaligned_w && !compressed_w;
        gain_alignment_w = emit_w && in_unaligned_w && compressed_w;
    end

    always_comb begin
        state_w = state_r;   // stall holds
        if (halt_w) begin
            state_w = S_HALTED;
        end else if (wait_w) begin
            state_w = S_STARTUP;
        end else if (aligned_jump_w || stay_aligned_w || gain_alignment_w) begin
            state_w = S_ALIGNED;
        end else if (unaligned_jump_2_w || stay_unaligned_w || lose_alignment_w) begin
            state_w = S_UNALIGNED;
        end else if (unaligned_jump_1_w) begin
            state_w = S_UNALIGNED_JUMP;
        end
    end

    // memory address, presented straight to the ram
    always_comb begin
        imem_addr_w = imem_addr_r;   // stall, or upper half still pending
        if (halt_w || wait_w) begin
            imem_addr_w = '0;
        end else if (aligned_jump_w || unaligned_jump_1_w) begin
            imem_addr_w = {jmp_addr_i[31:2], 2'b00};
        end else if (stay_aligned_w || lose_alignment_w || stay_unaligned_w ||
                     unaligned_jump_2_w) begin
            imem_addr_w = imem_addr_r + 32'd4;
        end
    end

    // candidate instr depends on where it starts in the word
    always_comb begin
        case (state_r)
            S_STARTUP,
            S_ALIGNED:   cand_ir_w = imem_data_i;
            S_UNALIGNED: cand_ir_w = {imem_data_i[15:0], saved_ir_r};
            default:     cand_ir_w = `NOP_IR;
        endcase
    end

    cpu_decompress u_decompress (
        .ir_i         (cand_ir_w),
        .ir_o         (expanded_ir_w),
        .compressed_o (compressed_w)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r       <= S_STARTUP;
            first_cycle_r <= 2'b11;
            imem_addr_r   <= '0;
        end else begin
            state_r       <= state_w;
            first_cycle_r <= {1'b0, first_cycle_r[1]};
            imem_addr_r   <= imem_addr_w;
        end
    end

    // output slot, bubble unless an instr is emitted
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ir_r <= `NOP_IR;
            pc_r <= `NOP_PC;
        end else if (emit_w) begin
            ir_r <= expanded_ir_w;
            pc_r <= next_pc_r;
        end else if (!stall_w) begin
            ir_r <= `NOP_IR;
            pc_r <= `NOP_PC;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            next_pc_r <= '0;
        end else if (halt_w) begin
            next_pc_r <= `NOP_PC;
        end else if (wait_w) begin
            next_pc_r <= '0;
        end else if (aligned_jump_w || unaligned_jump_1_w) begin
            next_pc_r <= jmp_addr_i;
        end else if (unaligned_jump_2_w) begin
            next_pc_r <= jmp_addr_r;
        end else if (emit_w) begin
            next_pc_r <= next_pc_r + (compressed_w ? 32'd2 : 32'd4);
        end
    end

    always_ff @(posedge clk_i) begin
        if (unaligned_jump_1_w) begin
            jmp_addr_r <= jmp_addr_i;
        end
    end

    // keep the upper half whenever the next instr starts there
    always_ff @(posedge clk_i) begin
        if (lose_alignment_w || stay_unaligned_w || unaligned_jump_2_w) begin
            saved_ir_r <= imem_data_i[31:16];
        end
    end

    assign imem_addr_o = imem_addr_w;
    assign pc_o        = pc_r;
    assign next_pc_o   = next_pc_r;
    assign ir_o        = ir_r;

endmodule

/* verilog/cpu_imem.sv */
`include "cpu_params.svh"

module cpu_imem (
    input  logic                clk_i,
    input  cpu_pkg::addr_t      raddr_i,   // byte address
    output cpu_pkg::word_t      rdata_o,
    input  logic                we_i,
    input  logic [`IMEM_AW-1:0] waddr_i,   // word index
    input  cpu_pkg::word_t      wdata_i
);
    import cpu_pkg::*;

    word_t               mem_r [`IMEM_DEPTH];
    logic [`IMEM_AW-1:0] ridx_w;

    // word index, byte offset dropped
    assign ridx_w = raddr_i[`IMEM_AW+1:2];

    // registered read, data one clock after the address
    always_ff @(posedge clk_i) begin
        rdata_o <= mem_r[ridx_w];
    end

    // load port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_r[waddr_i] <= wdata_i;
        end
    end

endmodule

/* verilog/cpu_fetch_top.sv */
`include "cpu_params.svh"

module cpu_fetch_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                halt_i,
    input  logic                ready_i,
    input  logic                jmp_valid_i,
    input  logic                load_we_i,     // program load, only while halted
    input  cpu_pkg::addr_t      jmp_addr_i,
    input  logic [`IMEM_AW-1:0] load_addr_i,
    input  cpu_pkg::word_t      load_data_i,
    output cpu_pkg::addr_t      pc_o,
    output cpu_pkg::addr_t      next_pc_o,
    output cpu_pkg::word_t      ir_o
);
    import cpu_pkg::*;

    addr_t imem_addr_w;
    word_t imem_data_w;

    cpu_imem u_imem (
        .clk_i   (clk_i),
        .raddr_i (imem_addr_w),
        .rdata_o (imem_data_w),
        .we_i    (load_we_i),
        .waddr_i (load_addr_i),
        .wdata_i (load_data_i)
    );

    cpu_if u_if (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .halt_i      (halt_i),
        .ready_i     (ready_i),
        .jmp_valid_i (jmp_valid_i),
        .jmp_addr_i  (jmp_addr_i),
        .imem_data_i (imem_data_w),
        .imem_addr_o (imem_addr_w),
        .pc_o        (pc_o),
        .next_pc_o   (next_pc_o),
        .ir_o        (ir_o)
    );

endmodule

/* sim/tb_cpu_fetch.sv */
`include "cpu_params.svh"

module tb_cpu_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int N_HALF     = 48;
    localparam int N_EXP      = 20;
    localparam int N_ROWS     = 4;
    localparam int WAIT_LIMIT = 50;

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic                halt_i;
    logic                ready_i;
    logic                jmp_valid_i;
    logic                load_we_i;
    addr_t               jmp_addr_i;
    logic [`IMEM_AW-1:0] load_addr_i;
    word_t               load_data_i;
    addr_t               pc_o;
    addr_t               next_pc_o;
    word_t               ir_o;

    // program image, one halfword per entry from byte address 0
    half_t prog [N_HALF] = '{
        16'h0093, 16'h0050, 16'h0113, 16'h0070, 16'h81B3, 16'h0020, 16'h5237, 16'h1234,
        16'h428D, 16'h0313, 16'hFFF0, 16'h8396, 16'h939A, 16'h0285, 16'h4044, 16'hC404,
        16'h6505, 16'hA839, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
        16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
        16'h0593, 16'h0400, 16'hC419, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
        16'h0000, 16'h0613, 16'h0020, 16'hE091, 16'h0001, 16'h5237, 16'h1234, 16'h0000};

    // expected stream in program order, ir already expanded
    addr_t exp_pc [N_EXP] = '{0, 4, 8, 12, 16, 18, 22, 24, 26, 28, 30, 32, 34,
                              64, 68, 82, 86, 88, 90, 94};
    word_t exp_ir [N_EXP] = '{
        32'h00500093, 32'h00700113, 32'h002081B3, 32'h12345237, 32'h00300293,
        32'hFFF00313, 32'h005003B3, 32'h006383B3, 32'h00128293, 32'h00442483,
        32'h00942423, 32'h00001537, 32'h01E0006F, 32'h04000593, 32'h00040763,
        32'h00200613, 32'h00049263, 32'h00000013, 32'h12345237, 32'h00000000};

    // stimulus rows: outputs to take, random ready, jump after, halt after
    int    row_count  [N_ROWS] = '{4, 9, 2, 5};
    logic  row_rand   [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    logic  row_jmp    [N_ROWS] = '{1'b0, 1'b1, 1'b1, 1'b0};
    addr_t row_target [N_ROWS] = '{32'd0, 32'd64, 32'd82, 32'd0};
    logic  row_halt   [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1};

    logic [15:0] lfsr_r = 16'd73;
    int          exp_idx;
    addr_t       prev_pc;
    addr_t       prev_next_pc;
    word_t       prev_ir;

    cpu_fetch_top u_dut (.*);

    always #5 clk_i = ~clk_i;

    // maximal 16-bit galois lfsr
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic observe_cycle();
        if (pc_o === `NOP_PC) begin
            check_word("ir_o", ir_o, `NOP_IR);   // bubbles carry a nop
        end
        if (!ready_i && !halt_i) begin           // stalled edge holds everything
            check_word("pc_o", pc_o, prev_pc);
            check_word("ir_o", ir_o, prev_ir);
            check_word("next_pc_o", next_pc_o, prev_next_pc);
        end
        prev_pc      = pc_o;
        prev_ir      = ir_o;
        prev_next_pc = next_pc_o;
    endtask

    task automatic drive_ready(input logic rand_rdy);
        if (rand_rdy) begin
            ready_i = lfsr_r[0];
            lfsr_r  = lfsr_step(lfsr_r);
        end else begin
            ready_i = 1'b1;
        end
    endtask

    task automatic wait_output(input logic rand_rdy);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found) begin
            drive_ready(rand_rdy);
            @(posedge clk_i);
            #1;
            found = (pc_o !== `NOP_PC) && ready_i;   // new only after a ready edge
            observe_cycle();
            cycles++;
            if (!found && cycles >= WAIT_LIMIT) begin
                $display("timeout: no valid instruction within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
        end
    endtask

    task automatic check_output();
        int    hidx;
        addr_t step;
        hidx = int'(exp_pc[exp_idx] >> 1);
        step = (prog[hidx][1:0] == 2'b11) ? 32'd4 : 32'd2;
        check_word("pc_o", pc_o, exp_pc[exp_idx]);
        check_word("ir_o", ir_o, exp_ir[exp_idx]);
        check_word("next_pc_o", next_pc_o, exp_pc[exp_idx] + step);
        exp_idx++;
    endtask

    task automatic take_jump(input addr_t target);
        jmp_valid_i = 1'b1;
        jmp_addr_i  = target;
        ready_i     = 1'b1;   // strobe only counts with ready high
        @(posedge clk_i);
        #1;
        observe_cycle();
        check_word("pc_o", pc_o, `NOP_PC);
        jmp_valid_i = 1'b0;
    endtask

    task automatic check_halt();
        halt_i = 1'b1;
        for (int i = 0; i < 20; i++) begin
            drive_ready(1'b1);   // halt wins over any ready level
            @(posedge clk_i);
            #1;
            observe_cycle();
            check_word("pc_o", pc_o, `NOP_PC);
            check_word("ir_o", ir_o, `NOP_IR);
        end
    endtask

    task automatic apply_reset(input logic halt);
        halt_i = halt;
        rst_i  = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk_i);
        end
        #1;
        rst_i        = 1'b0;
        prev_pc      = pc_o;
        prev_ir      = ir_o;
        prev_next_pc = next_pc_o;
    endtask

    task automatic load_program();
        for (int w = 0; w < N_HALF / 2; w++) begin
            load_we_i   = 1'b1;
            load_addr_i = w[`IMEM_AW-1:0];
            load_data_i = {prog[2*w+1], prog[2*w]};   // little endian halfwords
            @(posedge clk_i);
            #1;
        end
        load_we_i = 1'b0;
    endtask

    initial begin
        rst_i       = 1'b1;
        halt_i      = 1'b1;
        ready_i     = 1'b0;
        jmp_valid_i = 1'b0;
        jmp_addr_i  = '0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        exp_idx     = 0;
        apply_reset(1'b1);
        load_program();
        apply_reset(1'b0);
        for (int r = 0; r < N_ROWS; r++) begin
            for (int n = 0; n < row_count[r]; n++) begin
                wait_output(row_rand[r]);
                check_output();
            end
            if (row_jmp[r]) begin
                take_jump(row_target[r]);
            end
            if (row_halt[r]) begin
                check_halt();
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_decompress.sv
verilog/cpu_if.sv
verilog/cpu_imem.sv
verilog/cpu_fetch_top.sv
sim/tb_cpu_fetch.sv

/* Bender.yml */
package:
  name: cpu_fetch

export_include_dirs:
  - include

sources:
  - verilog/cpu_pkg.sv
  - verilog/cpu_decompress.sv
  - verilog/cpu_if.sv
  - verilog/cpu_imem.sv
  - verilog/cpu_fetch_top.sv
  - target: test
    files:
      - sim/tb_cpu_fetch.sv
